/* source/dcache_geom_pkg.sv */
// cache geometry shared by RTL and testbench; line length and address width are fixed here
// set and way counts are module parameters and must be powers of two, at least 2
package dcache_geom_pkg;

   localparam int ADDR_W       = 32;                // byte address width
   localparam int DATA_W       = 32;                // load/store word width
   localparam int CL_LEN       = 16;                // line length in bytes
   localparam int LINE_W       = CL_LEN * 8;        // line width in bits
   localparam int OFFSET_W     = $clog2(CL_LEN);    // byte offset within a line

   localparam int NUM_WAYS_DEF = 4;                 // default associativity
   localparam int NUM_SETS_DEF = 8;                 // default set count

   // ------------------------------------------------------------------
   // address field helpers
   // ------------------------------------------------------------------

   // byte position inside the line
   function automatic logic [OFFSET_W-1:0] offset_of(input logic [ADDR_W-1:0] addr);
      return addr[OFFSET_W-1:0];
   endfunction

   // line address, tag above set
   function automatic logic [ADDR_W-OFFSET_W-1:0] line_of(input logic [ADDR_W-1:0] addr);
      return addr[ADDR_W-1:OFFSET_W];
   endfunction

endpackage

/* source/dcache_bus_pkg.sv */
// CPU and arbiter side types; access size values equal their byte count
package dcache_bus_pkg;

   // size of a load or store in bytes
   typedef enum logic [2:0]
   {
      SIZE_BYTE = 3'd1,
      SIZE_HALF = 3'd2,
      SIZE_WORD = 3'd4
   } access_size_t;

   typedef logic [dcache_geom_pkg::DATA_W-1:0] word_t;     // load/store data
   typedef logic [dcache_geom_pkg::LINE_W-1:0] line_t;     // whole cache line

   // arbiter request direction
   localparam logic ARB_READ  = 1'b1;                      // line fetch, answered by an ack
   localparam logic ARB_WRITE = 1'b0;                      // write-back, no ack

endpackage

/* source/dcache_lookup_if.sv */
`timescale 1ns/100ps
// lookup path between controller, tag store and LRU; one set is looked at per cycle
interface dcache_lookup_if
#(
   parameter int NUM_WAYS = dcache_geom_pkg::NUM_WAYS_DEF,
   parameter int NUM_SETS = dcache_geom_pkg::NUM_SETS_DEF
);
   import dcache_geom_pkg::*;

   localparam int WAY_W = $clog2(NUM_WAYS);
   localparam int SET_W = $clog2(NUM_SETS);
   localparam int TAG_W = ADDR_W - OFFSET_W - SET_W;

   logic [SET_W-1:0] set;              // set of the current access
   logic [TAG_W-1:0] tag;              // tag of the current access
   logic             hit;              // tag matched a valid way
   logic [WAY_W-1:0] way;              // hit, empty or LRU way
   logic             victim_dirty;     // dirty bit of that way
   logic [TAG_W-1:0] victim_tag;       // stored tag of that way
   logic             touch;            // mark way as most recently used
   logic [WAY_W-1:0] lru_way;          // rank 0 way of the set

   modport ctrl (output set, tag, touch, input hit, way, victim_dirty, victim_tag);
   modport tags (input set, tag, lru_way, output hit, way, victim_dirty, victim_tag);
   modport lru  (input set, way, touch, output lru_way);

endinterface

/* source/dcache_tag_array.sv */
`timescale 1ns/100ps
// valid, dirty and tag per set and way; search is combinational, updates land at the edge
module dcache_tag_array
#(
   parameter int NUM_WAYS = dcache_geom_pkg::NUM_WAYS_DEF,
   parameter int NUM_SETS = dcache_geom_pkg::NUM_SETS_DEF
)
(
   input  logic             clk_in,
   input  logic             reset_in,
   dcache_lookup_if.tags    lookup,
   input  logic             fill,              // new line written, tag valid and clean
   input  logic             mark_dirty,        // store hit
   input  logic             clean              // victim written back
);
   import dcache_geom_pkg::*;

   localparam int WAY_W = $clog2(NUM_WAYS);
   localparam int SET_W = $clog2(NUM_SETS);
   localparam int TAG_W = ADDR_W - OFFSET_W - SET_W;

   logic [NUM_WAYS-1:0] valid   [NUM_SETS];
   logic [NUM_WAYS-1:0] dirty   [NUM_SETS];
   logic [TAG_W-1:0]    tag_mem [NUM_SETS][NUM_WAYS];

   logic                hit_found, empty_found;
   logic [WAY_W-1:0]    hit_way, empty_way, sel_way;

   // ------------------------------------------------------------------
   // parallel search of the set
   // ------------------------------------------------------------------
   always_comb
   begin
      hit_found   = 1'b0;
      hit_way     = '0;
      empty_found = 1'b0;
      empty_way   = '0;
      for (int w = 0; w < NUM_WAYS; w++)
      begin
         if (!valid[lookup.set][w])
         begin
            empty_found = 1'b1;
            empty_way   = WAY_W'(w);                       // later ways win, highest empty kept
         end
         else if (tag_mem[lookup.set][w] == lookup.tag)
         begin
            hit_found = 1'b1;
            hit_way   = WAY_W'(w);
         end
      end
   end

   // hit first, then an empty way, then the LRU way
   assign sel_way             = hit_found ? hit_way : (empty_found ? empty_way : lookup.lru_way);
   assign lookup.hit          = hit_found;
   assign lookup.way          = sel_way;
   assign lookup.victim_dirty = dirty[lookup.set][sel_way];     // never set on an invalid way
   assign lookup.victim_tag   = tag_mem[lookup.set][sel_way];

   // ------------------------------------------------------------------
   // state updates
   // ------------------------------------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (reset_in)
      begin
         valid <= '{default: '0};                          // all lines invalid
         dirty <= '{default: '0};
      end
      else if (fill)
      begin
         valid[lookup.set][sel_way] <= 1'b1;
         dirty[lookup.set][sel_way] <= 1'b0;               // fresh copy of memory
      end
      else if (mark_dirty)
         dirty[lookup.set][sel_way] <= 1'b1;
      else if (clean)
         dirty[lookup.set][sel_way] <= 1'b0;
   end

   always_ff @(posedge clk_in)
   begin
      if (fill)
         tag_mem[lookup.set][sel_way] <= lookup.tag;
   end

endmodule

/* source/dcache_lru.sv */
`timescale 1ns/100ps
// per-set LRU ranks, rank 0 is least recently used; ranks in a set stay a permutation
module dcache_lru
#(
   parameter int NUM_WAYS = dcache_geom_pkg::NUM_WAYS_DEF,
   parameter int NUM_SETS = dcache_geom_pkg::NUM_SETS_DEF
)
(
   input  logic             clk_in,
   input  logic             reset_in,
   dcache_lookup_if.lru     lookup
);
   localparam int WAY_W = $clog2(NUM_WAYS);

   logic [WAY_W-1:0] rank      [NUM_SETS][NUM_WAYS];
   logic [WAY_W-1:0] next_rank [NUM_WAYS];
   logic [WAY_W-1:0] cur_rank;                               // rank of the touched way
   logic [WAY_W-1:0] oldest;

   // victim candidate of the current set
   always_comb
   begin
      oldest = '0;
      for (int w = 0; w < NUM_WAYS; w++)
      begin
         if (rank[lookup.set][w] == '0)
            oldest = WAY_W'(w);
      end
   end

   assign lookup.lru_way = oldest;
   assign cur_rank       = rank[lookup.set][lookup.way];

   // touched way goes to the top, the ones above it move down by one
   always_comb
   begin
      for (int w = 0; w < NUM_WAYS; w++)
      begin
         if (rank[lookup.set][w] > cur_rank)
            next_rank[w] = rank[lookup.set][w] - 1'b1;
         else if (rank[lookup.set][w] == cur_rank)
            next_rank[w] = WAY_W'(NUM_WAYS - 1);
         else
            next_rank[w] = rank[lookup.set][w];
      end
   end

   always_ff @(posedge clk_in)
   begin
      if (reset_in)
      begin
         for (int s = 0; s < NUM_SETS; s++)
         begin
            for (int w = 0; w < NUM_WAYS; w++)
               rank[s][w] <= WAY_W'(w);                       // way w starts at rank w
         end
      end
      else if (lookup.touch)
      begin
         for (int w = 0; w < NUM_WAYS; w++)
            rank[lookup.set][w] <= next_rank[w];
      end
   end

endmodule

/* source/dcache_data_array.sv */
`timescale 1ns/100ps
// line storage with combinational read; store bytes must not cross the line end
module dcache_data_array
#(
   parameter int  NUM_WAYS = dcache_geom_pkg::NUM_WAYS_DEF,
   parameter int  NUM_SETS = dcache_geom_pkg::NUM_SETS_DEF,
   localparam int WAY_W    = $clog2(NUM_WAYS),
   localparam int SET_W    = $clog2(NUM_SETS)
)
(
   input  logic                                clk_in,
   input  logic [SET_W-1:0]                    set,
   input  logic [WAY_W-1:0]                    way,
   input  logic [dcache_geom_pkg::OFFSET_W-1:0] offset,
   input  dcache_bus_pkg::access_size_t        size,
   input  logic                                zero_ext,     // 1 zero extends, 0 sign extends
   input  dcache_bus_pkg::word_t               wr_data,
   input  logic                                store,        // merge store bytes
   input  logic                                fill,         // write whole line
   input  dcache_bus_pkg::line_t               fill_data,
   output dcache_bus_pkg::line_t               line_out,
   output dcache_bus_pkg::word_t               load_data
);
   import dcache_geom_pkg::*;
   import dcache_bus_pkg::*;

   line_t                mem [NUM_SETS][NUM_WAYS];
   line_t                merged;
   line_t                shifted;
   word_t                raw;
   logic [OFFSET_W+2:0]  bit_off;                            // offset in bits

   assign line_out = mem[set][way];
   assign bit_off  = {offset, 3'b000};
   assign shifted  = line_out >> bit_off;                    // addressed byte to bit 0
   assign raw      = shifted[DATA_W-1:0];

   // load extract with extension
   always_comb
   begin
      case (size)
         SIZE_BYTE: load_data = {{24{~zero_ext & raw[7]}}, raw[7:0]};
         SIZE_HALF: load_data = {{16{~zero_ext & raw[15]}}, raw[15:0]};
         default:   load_data = raw;                         // word needs no extension
      endcase
   end

   // store byte merge
   always_comb
   begin
      merged = line_out;
      case (size)
         SIZE_BYTE: merged[bit_off +: 8]  = wr_data[7:0];
         SIZE_HALF: merged[bit_off +: 16] = wr_data[15:0];
         default:   merged[bit_off +: 32] = wr_data;
      endcase
   end

   always_ff @(posedge clk_in)
   begin
      if (fill)
         mem[set][way] <= fill_data;
      else if (store)
         mem[set][way] <= merged;
   end

endmodule

/* source/dcache_ctrl.sv */
`timescale 1ns/100ps
// miss/hit FSM; a miss writes back a dirty victim, fetches the line, then hits in idle
module dcache_ctrl
#(
   parameter int  NUM_SETS = dcache_geom_pkg::NUM_SETS_DEF,
   localparam int SET_W    = $clog2(NUM_SETS),
   localparam int LADDR_W  = dcache_geom_pkg::ADDR_W - dcache_geom_pkg::OFFSET_W,
   localparam int TAG_W    = LADDR_W - SET_W
)
(
   input  logic                clk_in,
   input  logic                reset_in,
   input  logic                req,
   input  logic                req_wr,
   input  logic [SET_W-1:0]    set,
   input  logic [TAG_W-1:0]    tag,
   input  logic                arb_req_rdy,
   input  logic                arb_ack_valid,
   dcache_lookup_if.ctrl       lookup,
   output logic                ack,
   output logic                arb_req_valid,
   output logic                arb_req_rw,
   output logic [LADDR_W-1:0]  arb_req_addr,          // line address, tag and set
   output logic                arb_ack_rdy,
   output logic                tag_fill,
   output logic                tag_dirty,
   output logic                tag_clean,
   output logic                data_store,
   output logic                data_fill
);
   import dcache_bus_pkg::*;

   typedef enum logic [1:0] {IDLE, WRITEBACK, FILL_REQ, FILL_WAIT} state_t;

   state_t state, next_state;

   assign lookup.set = set;                           // held by the CPU until ack
   assign lookup.tag = tag;

   always_ff @(posedge clk_in)
   begin
      if (reset_in)
         state <= IDLE;
      else
         state <= next_state;
   end

   // ------------------------------------------------------------------
   // next state and strobes
   // ------------------------------------------------------------------
   always_comb
   begin
      next_state    = state;
      ack           = 1'b0;
      lookup.touch  = 1'b0;
      arb_req_valid = 1'b0;
      arb_req_rw    = ARB_READ;
      arb_req_addr  = {tag, set};
      arb_ack_rdy   = 1'b0;
      tag_fill      = 1'b0;
      tag_dirty     = 1'b0;
      tag_clean     = 1'b0;
      data_store    = 1'b0;
      data_fill     = 1'b0;

      case (state)
         IDLE:
         begin
            if (req && lookup.hit)
            begin
               ack          = 1'b1;                   // hit answers in the same cycle
               lookup.touch = 1'b1;
               data_store   = req_wr;
               tag_dirty    = req_wr;
            end
            else if (req)
               next_state = lookup.victim_dirty ? WRITEBACK : FILL_REQ;
         end

         WRITEBACK:
         begin
            arb_req_valid = 1'b1;
            arb_req_rw    = ARB_WRITE;
            arb_req_addr  = {lookup.victim_tag, set}; // victim home address
            if (arb_req_rdy)
            begin
               tag_clean  = 1'b1;                     // memory now holds the line
               next_state = FILL_REQ;
            end
         end

         FILL_REQ:
         begin
            arb_req_valid = 1'b1;                     // read of the missing line
            if (arb_req_rdy)
               next_state = FILL_WAIT;
         end

         FILL_WAIT:
         begin
            arb_ack_rdy = 1'b1;
            if (arb_ack_valid)
            begin
               tag_fill   = 1'b1;
               data_fill  = 1'b1;
               next_state = IDLE;                     // replayed there as a hit
            end
         end

         default:
            next_state = IDLE;
      endcase
   end

endmodule

/* source/l1_dcache.sv */
`timescale 1ns/100ps
// set-associative write-back L1 data cache with LRU; accesses must be naturally aligned
// one CPU access in flight, no flush, a miss is replayed as a hit once the line is in
module l1_dcache
#(
   parameter int NUM_WAYS = dcache_geom_pkg::NUM_WAYS_DEF,
   parameter int NUM_SETS = dcache_geom_pkg::NUM_SETS_DEF
)
(
   input  logic                                  clk_in,
   input  logic                                  reset_in,

   // CPU side, level request with one-cycle ack
   input  logic                                  req,
   input  logic                                  req_wr,
   input  dcache_bus_pkg::access_size_t          req_size,
   input  logic                                  req_zero_ext,
   input  logic [dcache_geom_pkg::ADDR_W-1:0]    req_addr,
   input  dcache_bus_pkg::word_t                 req_wr_data,
   output logic                                  ack,
   output dcache_bus_pkg::word_t                 ack_data,

   // arbiter side, valid/ready both ways
   output logic                                  arb_req_valid,
   input  logic                                  arb_req_rdy,
   output logic                                  arb_req_rw,
   output logic [dcache_geom_pkg::ADDR_W-dcache_geom_pkg::OFFSET_W-1:0] arb_req_addr,
   output dcache_bus_pkg::line_t                 arb_req_wr_data,
   input  logic                                  arb_ack_valid,
   output logic                                  arb_ack_rdy,
   input  dcache_bus_pkg::line_t                 arb_ack_data
);
   import dcache_geom_pkg::*;

   localparam int SET_W = $clog2(NUM_SETS);
   localparam int TAG_W = ADDR_W - OFFSET_W - SET_W;

   logic [ADDR_W-OFFSET_W-1:0] line_addr;
   logic [OFFSET_W-1:0]        offset;
   logic [SET_W-1:0]           set;
   logic [TAG_W-1:0]           tag;
   logic                       tag_fill, tag_dirty, tag_clean;     // tag store strobes
   logic                       data_store, data_fill;              // data store strobes

   assign line_addr = line_of(req_addr);
   assign offset    = offset_of(req_addr);
   assign set       = line_addr[SET_W-1:0];                        // set index right above offset
   assign tag       = line_addr[SET_W +: TAG_W];

   dcache_lookup_if #(.NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS)) lookup ();

   dcache_ctrl #(.NUM_SETS(NUM_SETS)) u_ctrl
   (
      .clk_in, .reset_in, .req, .req_wr, .set, .tag,
      .arb_req_rdy, .arb_ack_valid,
      .lookup        (lookup.ctrl),
      .ack, .arb_req_valid, .arb_req_rw, .arb_req_addr, .arb_ack_rdy,
      .tag_fill, .tag_dirty, .tag_clean, .data_store, .data_fill
   );

   dcache_tag_array #(.NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS)) u_tags
   (
      .clk_in, .reset_in,
      .lookup        (lookup.tags),
      .fill          (tag_fill),
      .mark_dirty    (tag_dirty),
      .clean         (tag_clean)
   );

   dcache_lru #(.NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS)) u_lru
   (
      .clk_in, .reset_in,
      .lookup        (lookup.lru)
   );

   dcache_data_array #(.NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS)) u_data
   (
      .clk_in, .set,
      .way           (lookup.way),                                 // same way as the tag store
      .offset,
      .size          (req_size),
      .zero_ext      (req_zero_ext),
      .wr_data       (req_wr_data),
      .store         (data_store),
      .fill          (data_fill),
      .fill_data     (arb_ack_data),
      .line_out      (arb_req_wr_data),                            // victim line for write-back
      .load_data     (ack_data)
   );

endmodule

/* verif/dcache_assertions.sv */
`timescale 1ns/100ps
// bound into l1_dcache; checks CPU alignment and the arbiter handshake rules
module dcache_assertions
(
   input  logic                                clk_in,
   input  logic                                reset_in,
   input  logic                                req,
   input  dcache_bus_pkg::access_size_t        req_size,
   input  logic [dcache_geom_pkg::ADDR_W-1:0]  req_addr,
   input  logic                                ack,
   input  logic                                arb_req_valid,
   input  logic                                arb_req_rdy,
   input  logic                                arb_req_rw,
   input  logic [dcache_geom_pkg::ADDR_W-dcache_geom_pkg::OFFSET_W-1:0] arb_req_addr,
   input  logic                                arb_ack_rdy
);
   import dcache_bus_pkg::*;

   logic aligned;                                    // address is a multiple of the size

   always_comb
   begin
      case (req_size)
         SIZE_HALF: aligned = ~req_addr[0];
         SIZE_WORD: aligned = (req_addr[1:0] == 2'b00);
         default:   aligned = 1'b1;                  // bytes are always aligned
      endcase
   end

   a_aligned: assert property (@(posedge clk_in) disable iff (reset_in) req |-> aligned)
      else $error("request address %h is not aligned to its size", req_addr);

   // a pending arbiter request holds until it is taken
   a_req_hold: assert property (@(posedge clk_in) disable iff (reset_in)
      (arb_req_valid && !arb_req_rdy) |=>
      (arb_req_valid && $stable(arb_req_addr) && $stable(arb_req_rw)))
      else $error("arbiter request dropped or changed before transfer");

   a_ack_pulse: assert property (@(posedge clk_in) disable iff (reset_in)
      (req && ack) |=> !ack)
      else $error("ack high for two cycles in a row");

   a_one_side: assert property (@(posedge clk_in) disable iff (reset_in)
      !(arb_ack_rdy && arb_req_valid))
      else $error("arbiter request and refill ready high together");

endmodule

bind l1_dcache dcache_assertions u_assertions
(
   .clk_in, .reset_in, .req, .req_size, .req_addr, .ack,
   .arb_req_valid, .arb_req_rdy, .arb_req_rw, .arb_req_addr, .arb_ack_rdy
);

/* verif/tb_l1_dcache.sv */
`timescale 1ns/100ps
// 4 ways, 8 sets; all table lines map to set 0 to force LRU eviction and write-back
// lines never written back read as an address pattern from the arbiter model
module tb_l1_dcache;
   import dcache_geom_pkg::*;
   import dcache_bus_pkg::*;

   localparam int NUM_ROWS    = 20;
   localparam int CYCLE_LIMIT = NUM_ROWS * 40;

   localparam logic [ADDR_W-1:0] ADDR_A = 32'h0001_2380;   // set bits [6:4] all zero
   localparam logic [ADDR_W-1:0] ADDR_B = 32'h0002_4580;
   localparam logic [ADDR_W-1:0] ADDR_C = 32'h0003_6780;
   localparam logic [ADDR_W-1:0] ADDR_D = 32'h0004_8980;
   localparam logic [ADDR_W-1:0] ADDR_E = 32'h0005_ab80;

   typedef logic [ADDR_W-OFFSET_W-1:0] laddr_t;

   typedef struct packed
   {
      logic              wr;
      access_size_t      size;
      logic              zext;
      logic [ADDR_W-1:0] addr;
      word_t             wdata;
      word_t             exp_data;                           // read result, unused on stores
   } access_row_t;

   logic              clk_in = 1'b0;
   logic              reset_in;
   logic              req, req_wr, req_zero_ext;
   access_size_t      req_size;
   logic [ADDR_W-1:0] req_addr;
   word_t             req_wr_data, ack_data;
   logic              ack, arb_req_valid, arb_req_rdy, arb_req_rw;
   laddr_t            arb_req_addr;
   line_t             arb_req_wr_data, arb_ack_data;
   logic              arb_ack_valid, arb_ack_rdy;

   access_row_t       rows [NUM_ROWS];
   int                n_rows = 0;
   logic              verdict_done = 1'b0;
   logic [31:0]       lfsr = 32'hbc83_ae38;
   laddr_t            cur_line;                               // line of the access in flight
   line_t             mem_lines [laddr_t];                    // lines written back so far
   laddr_t            wb_addr_q [$];
   line_t             wb_data_q [$];

   l1_dcache #(.NUM_WAYS(4), .NUM_SETS(8)) dut (.*);

   always #50 clk_in = ~clk_in;

   // ------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------
   function automatic logic random_bit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];         // x^32 + x^22 + x^2 + x + 1
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic word_t pattern_word(input logic [ADDR_W-1:0] addr);
      logic [ADDR_W-1:0] a;
      a = {addr[ADDR_W-1:2], 2'b00};
      return (a * 32'h9e37_79b1) ^ 32'h5bd1_e995;             // mixes every address bit
   endfunction

   function automatic line_t pattern_line(input laddr_t laddr);
      line_t l;
      for (int i = 0; i < 4; i++)
         l[32*i +: 32] = pattern_word({laddr, 4'(4 * i)});
      return l;
   endfunction

   function automatic line_t memory_line(input laddr_t laddr);
      return mem_lines.exists(laddr) ? mem_lines[laddr] : pattern_line(laddr);
   endfunction

   // untouched memory as seen by a load
   function automatic word_t pattern_load(input logic [ADDR_W-1:0] addr,
                                          input access_size_t size, input logic zext);
      word_t w;
      w = pattern_word(addr) >> (8 * addr[1:0]);
      case (size)
         SIZE_BYTE: return zext ? {24'h0, w[7:0]} : {{24{w[7]}}, w[7:0]};
         SIZE_HALF: return zext ? {16'h0, w[15:0]} : {{16{w[15]}}, w[15:0]};
         default:   return w;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [127:0] got,
                              input logic [127:0] want);
      if (got !== want)
      begin
         $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, want);
         verdict_done = 1'b1;
         $display("Regression failed");
         $fatal(1, "compare failed");
      end
   endtask

   task automatic add_row(input logic wr, input access_size_t size, input logic zext,
                          input logic [ADDR_W-1:0] addr, input word_t wdata, input word_t want);
      rows[n_rows] = '{wr, size, zext, addr, wdata, want};
      n_rows++;
   endtask

   // one CPU access, held until ack, then one idle cycle
   task automatic run_access(input access_row_t row);
      logic got_ack;
      got_ack      = 1'b0;
      cur_line     = row.addr[ADDR_W-1:OFFSET_W];
      req          = 1'b1;
      req_wr       = row.wr;
      req_size     = row.size;
      req_zero_ext = row.zext;
      req_addr     = row.addr;
      req_wr_data  = row.wdata;
      while (!got_ack)
      begin
         @(negedge clk_in);
         if (ack)
         begin
            got_ack = 1'b1;
            if (!row.wr)
               check_value("ack_data", 128'(ack_data), 128'(row.exp_data));
         end
         else
         begin
            @(posedge clk_in);
            #1;
         end
      end
      @(posedge clk_in);
      #1;
      req = 1'b0;
      @(posedge clk_in);
      #1;
   endtask

   // ------------------------------------------------------------------
   // arbiter memory model, handshakes sampled at the falling edge
   // ------------------------------------------------------------------
   initial
   begin
      logic   req_xfer, ack_xfer, rw_seen, pending, stall_bit;
      laddr_t addr_seen, pending_addr;
      line_t  data_seen;
      pending       = 1'b0;
      pending_addr  = '0;
      arb_req_rdy   = 1'b0;
      arb_ack_valid = 1'b0;
      arb_ack_data  = '0;
      forever
      begin
         @(negedge clk_in);
         req_xfer  = arb_req_valid && arb_req_rdy;
         ack_xfer  = arb_ack_valid && arb_ack_rdy;
         rw_seen   = arb_req_rw;
         addr_seen = arb_req_addr;
         data_seen = arb_req_wr_data;
         @(posedge clk_in);
         #1;
         if (ack_xfer)
            pending = 1'b0;                                   // refill taken
         if (req_xfer && rw_seen == ARB_WRITE)
         begin
            mem_lines[addr_seen] = data_seen;
            wb_addr_q.push_back(addr_seen);
            wb_data_q.push_back(data_seen);
         end
         else if (req_xfer)
         begin
            check_value("arb_req_addr", 128'(addr_seen), 128'(cur_line));
            pending      = 1'b1;
            pending_addr = addr_seen;
         end
         arb_req_rdy   = random_bit();
         stall_bit     = random_bit();
         arb_ack_valid = pending && stall_bit;
         arb_ack_data  = pending ? memory_line(pending_addr) : '0;
      end
   end

   initial
   begin
      int cycle_count;
      cycle_count = 0;
      while (cycle_count < CYCLE_LIMIT)
      begin
         @(posedge clk_in);
         cycle_count++;
      end
      $display("timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
      verdict_done = 1'b1;
      $display("Regression failed");
      $fatal(1, "cycle limit reached");
   end

   // ------------------------------------------------------------------
   // table and main sequence
   // ------------------------------------------------------------------
   initial
   begin
      line_t exp_b, exp_c;
      reset_in     = 1'b1;
      req          = 1'b0;
      req_wr       = 1'b0;
      req_size     = SIZE_WORD;
      req_zero_ext = 1'b0;
      req_addr     = '0;
      req_wr_data  = '0;

      add_row(0, SIZE_WORD, 0, ADDR_A,      '0, pattern_load(ADDR_A, SIZE_WORD, 0));
      add_row(0, SIZE_BYTE, 0, ADDR_A + 5,  '0, pattern_load(ADDR_A + 5, SIZE_BYTE, 0));
      add_row(1, SIZE_WORD, 0, ADDR_B,      32'h8765_4321, '0);
      add_row(1, SIZE_BYTE, 0, ADDR_B + 1,  32'h0000_00a5, '0);
      add_row(1, SIZE_HALF, 0, ADDR_B + 6,  32'h0000_f00d, '0);
      add_row(0, SIZE_WORD, 0, ADDR_B,      '0, 32'h8765_a521);
      add_row(0, SIZE_BYTE, 0, ADDR_B + 1,  '0, 32'hffff_ffa5);
      add_row(0, SIZE_BYTE, 1, ADDR_B + 1,  '0, 32'h0000_00a5);
      add_row(0, SIZE_HALF, 0, ADDR_B + 6,  '0, 32'hffff_f00d);
      add_row(0, SIZE_HALF, 1, ADDR_B + 6,  '0, 32'h0000_f00d);
      add_row(0, SIZE_HALF, 1, ADDR_B + 4,  '0, pattern_load(ADDR_B + 4, SIZE_HALF, 1));
      add_row(1, SIZE_WORD, 0, ADDR_C + 8,  32'h1357_9bdf, '0);      // store miss
      add_row(0, SIZE_WORD, 0, ADDR_D + 12, '0, pattern_load(ADDR_D + 12, SIZE_WORD, 0));
      add_row(0, SIZE_WORD, 0, ADDR_A,      '0, pattern_load(ADDR_A, SIZE_WORD, 0));
      add_row(0, SIZE_WORD, 0, ADDR_E + 4,  '0, pattern_load(ADDR_E + 4, SIZE_WORD, 0));
      add_row(0, SIZE_BYTE, 1, ADDR_E + 7,  '0, pattern_load(ADDR_E + 7, SIZE_BYTE, 1));
      add_row(0, SIZE_WORD, 0, ADDR_B,      '0, 32'h8765_a521);      // back from memory
      add_row(0, SIZE_HALF, 0, ADDR_B + 6,  '0, 32'hffff_f00d);
      add_row(0, SIZE_WORD, 0, ADDR_C + 8,  '0, 32'h1357_9bdf);
      add_row(0, SIZE_WORD, 0, ADDR_B + 4,  '0,
              pattern_load(ADDR_B + 4, SIZE_HALF, 1) | 32'hf00d_0000);

      repeat (4) @(posedge clk_in);
      #1;
      reset_in = 1'b0;
      @(negedge clk_in);
      check_value("ack", 128'(ack), '0);
      check_value("arb_req_valid", 128'(arb_req_valid), '0);
      check_value("arb_ack_rdy", 128'(arb_ack_rdy), '0);
      @(posedge clk_in);
      #1;

      for (int i = 0; i < n_rows; i++)
         run_access(rows[i]);

      // B evicted dirty by E, then C evicted dirty by the re-read of B
      exp_b          = pattern_line(ADDR_B[ADDR_W-1:OFFSET_W]);
      exp_b[31:0]    = 32'h8765_a521;
      exp_b[63:48]   = 16'hf00d;
      exp_c          = pattern_line(ADDR_C[ADDR_W-1:OFFSET_W]);
      exp_c[95:64]   = 32'h1357_9bdf;
      check_value("write-back count", 128'(wb_addr_q.size()), 128'(2));
      check_value("arb_req_addr", 128'(wb_addr_q[0]), 128'(ADDR_B[ADDR_W-1:OFFSET_W]));
      check_value("arb_req_wr_data", wb_data_q[0], exp_b);
      check_value("arb_req_addr", 128'(wb_addr_q[1]), 128'(ADDR_C[ADDR_W-1:OFFSET_W]));
      check_value("arb_req_wr_data", wb_data_q[1], exp_c);

      verdict_done = 1'b1;
      $display("Regression passed");
      $finish;
   end

   final
   begin
      if (!verdict_done)
         $display("Regression failed");
   end

endmodule

/* l1_dcache.f */
source/dcache_geom_pkg.sv
source/dcache_bus_pkg.sv
source/dcache_lookup_if.sv
source/dcache_tag_array.sv
source/dcache_lru.sv
source/dcache_data_array.sv
source/dcache_ctrl.sv
source/l1_dcache.sv
verif/dcache_assertions.sv
verif/tb_l1_dcache.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the l1_dcache testbench with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_l1_dcache \
   -f l1_dcache.f -o tb_l1_dcache_sim \
   && ./obj_dir/tb_l1_dcache_sim 2>&1 | tee sim.log \
   || { echo "build or simulation did not complete"; exit 1; }
grep -qx "Regression passed" sim.log \
   && echo "run.sh: PASS" \
   || { echo "run.sh: FAIL"; exit 1; }
